// File: Bender.yml
package:
  name: fighter

sources:
  - verilog/fighter_pkg.sv
  - verilog/pixel_if.sv
  - verilog/vga_timing.sv
  - verilog/sprite_motion.sv
  - verilog/pixel_colorizer.sv
  - verilog/apb_regs.sv
  - verilog/hex_display.sv
  - verilog/fighter_top.sv
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/tb_fighter.sv

// File: all.f
verilog/fighter_pkg.sv
verilog/pixel_if.sv
verilog/vga_timing.sv
verilog/sprite_motion.sv
verilog/pixel_colorizer.sv
verilog/apb_regs.sv
verilog/hex_display.sv
verilog/fighter_top.sv
verification/clk_gen.sv
verification/tb_fighter.sv

// File: verification/clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset held over the first rising edges
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verification/tb_fighter.sv
// sprite display testbench
`timescale 1ns/1ps
`default_nettype none

module tb_fighter
	import fighter_pkg::*;
();
	// tiny raster so a frame is only a few hundred clocks
	localparam int H_ACTIVE    = 16;
	localparam int H_FRONT     = 2;
	localparam int H_SYNC      = 2;
	localparam int H_BACK      = 2;
	localparam int V_ACTIVE    = 12;
	localparam int V_FRONT     = 1;
	localparam int V_SYNC      = 1;
	localparam int V_BACK      = 1;
	localparam int SPRITE_SIZE = 1;
	localparam int STEP        = 1;

	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 22
	localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 15
	localparam int FRAME_CYCLES = 2 * H_TOTAL * V_TOTAL;                // 660
	localparam int VIS_END      = 2 * H_TOTAL * (V_SYNC + V_BACK + V_ACTIVE);
	// worst case run is a little over 18 frames, motion alone takes 15
	localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES;

	localparam int X_MIN = SPRITE_SIZE;
	localparam int X_MAX = H_ACTIVE - 1 - SPRITE_SIZE;
	localparam int Y_MIN = SPRITE_SIZE;
	localparam int Y_MAX = V_ACTIVE - 1 - SPRITE_SIZE;

	logic        clk, rst;
	logic        psel, penable, pwrite;
	apb_addr_t   paddr;
	apb_data_t   pwdata, prdata;
	logic        pready, pslverr;
	logic        vga_hs, vga_vs;
	color_t      vga_r, vga_g, vga_b;
	logic [9:0]  ledr;
	logic [7:0]  hex0, hex1, hex2, hex3, hex4, hex5;

	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycles = 0;
	int unsigned seed;
	logic [31:0] rnd;

	clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clk (.clk(clk), .rst(rst));

	fighter_top #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
		.SPRITE_SIZE (SPRITE_SIZE), .STEP (STEP)
	) DUT (
		.clk (clk), .rst (rst),
		.psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
		.pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
		.vga_hs (vga_hs), .vga_vs (vga_vs), .vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
		.ledr (ledr), .hex0 (hex0), .hex1 (hex1), .hex2 (hex2),
		.hex3 (hex3), .hex4 (hex4), .hex5 (hex5)
	);

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: no result after %0d clk cycles", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ==================================================
	// reporting and reference tables
	// ==================================================
	task automatic report_mismatch(input string msg);
		$display("FAIL %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%-18s ok", name);
		end else begin
			tests_failed++;
			$display("%-18s %0d error(s)", name, errors - errs_before);
		end
	endtask

	// lit segments as gfedcba, active high
	function automatic logic [7:0] segments_for(input logic [3:0] d);
		logic [6:0] lit;
		case (d)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return {1'b1, ~lit}; // pins are active low, dp dark
	endfunction

	// cycle m counts from the first clk with vga_vs low; output lags the raster
	// by one clk, so m shows pixel m/2 past the start of line V_ACTIVE+V_FRONT
	function automatic int column_at(input int m);
		return (m / 2) % H_TOTAL;
	endfunction

	function automatic int line_at(input int m);
		return (V_ACTIVE + V_FRONT + (m / 2) / H_TOTAL) % V_TOTAL;
	endfunction

	// ==================================================
	// apb master
	// ==================================================
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1; // setup
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1; // access
		@(negedge clk);
		err = pslverr;
		if (pready !== 1'b1)
			report_problem("pready low during a write access");
		@(posedge clk); // write lands here
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata; // valid in the access cycle
		err  = pslverr;
		if (pready !== 1'b1)
			report_problem("pready low during a read access");
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_vs_fall;
		logic prev;
		@(negedge clk);
		prev = vga_vs;
		@(negedge clk);
		while (!(prev && !vga_vs)) begin
			prev = vga_vs;
			@(negedge clk);
		end
	endtask

	task automatic wait_next_frame(inout apb_data_t frames);
		apb_data_t now;
		logic      err;
		apb_read(REG_FRAMES, now, err);
		while (now == frames)
			apb_read(REG_FRAMES, now, err);
		if (now != frames + 1)
			report_mismatch($sformatf("frame count %0d after %0d", now, frames));
		frames = now;
	endtask

	// ==================================================
	// tests
	// ==================================================
	task automatic reset_and_registers;
		apb_addr_t zero_regs [4];
		apb_addr_t rw_regs [3];
		apb_data_t rw_vals [3];
		apb_data_t d;
		logic      err;
		int        i, errs_before;
		errs_before = errors;
		zero_regs = '{REG_KEYCODE, REG_HEX, REG_LEDS, REG_FRAMES};
		rw_regs   = '{REG_KEYCODE, REG_HEX, REG_LEDS};
		rw_vals   = '{32'h0000_00A5, 32'h0000_C3E1, 32'h0000_2A5C};
		for (i = 0; i < 4; i++) begin
			apb_read(zero_regs[i], d, err);
			if (d != 0 || err)
				report_mismatch($sformatf("reg %h after reset: %h err %b", zero_regs[i], d, err));
		end
		apb_read(REG_POS, d, err);
		if (d != {6'd0, 10'd6, 6'd0, 10'd8}) // screen centre
			report_mismatch($sformatf("position after reset %h", d));
		@(negedge clk);
		if (hex0 != segments_for(4'h0) || hex1 != segments_for(4'h0)
			|| hex3 != segments_for(4'h0) || hex4 != segments_for(4'h0))
			report_mismatch("digit displays not showing 0 after reset");
		if (hex2 != 8'hFF || hex5 != 8'hFF || ledr != 10'd0)
			report_mismatch($sformatf("marks %h/%h leds %h after reset", hex2, hex5, ledr));
		for (i = 0; i < 3; i++)
			apb_write(rw_regs[i], rw_vals[i], err);
		for (i = 0; i < 3; i++) begin
			apb_read(rw_regs[i], d, err);
			if (d != rw_vals[i] || err)
				report_mismatch($sformatf("reg %h reads %h, wrote %h", rw_regs[i], d, rw_vals[i]));
		end
		// illegal writes must bounce off
		apb_write(REG_POS, 32'h0003_0002, err);
		if (!err)
			report_problem("write to the position register gave no pslverr");
		apb_write(8'h20, 32'hFFFF_FFFF, err);
		if (!err)
			report_problem("write to unmapped address 0x20 gave no pslverr");
		apb_read(REG_POS, d, err);
		if (d != {6'd0, 10'd6, 6'd0, 10'd8})
			report_mismatch($sformatf("position changed to %h by a write", d));
		for (i = 0; i < 3; i++) begin
			apb_read(rw_regs[i], d, err);
			if (d != rw_vals[i])
				report_mismatch($sformatf("reg %h now %h after bad writes", rw_regs[i], d));
		end
		finish_test("reset and regs", errs_before);
	endtask

	task automatic hex_segments;
		apb_data_t  d;
		logic       err;
		logic [3:0] marks;
		logic [7:0] exp2, exp5;
		int         i, errs_before;
		errs_before = errors;
		for (i = 0; i < 8; i++) begin
			rnd = $urandom;
			d   = {16'd0, rnd[15:0]};
			apb_write(REG_HEX, d, err);
			@(negedge clk);
			if (hex0 != segments_for(d[3:0]))
				report_mismatch($sformatf("hex0 %h for digit %h", hex0, d[3:0]));
			if (hex1 != segments_for(d[7:4]))
				report_mismatch($sformatf("hex1 %h for digit %h", hex1, d[7:4]));
			if (hex3 != segments_for(d[11:8]))
				report_mismatch($sformatf("hex3 %h for digit %h", hex3, d[11:8]));
			if (hex4 != segments_for(d[15:12]))
				report_mismatch($sformatf("hex4 %h for digit %h", hex4, d[15:12]));
		end
		// walk each mark bit, then all four together
		for (i = 0; i < 5; i++) begin
			marks = (i < 4) ? 4'b0001 << i : 4'hF;
			rnd   = $urandom;
			d     = {18'd0, marks, rnd[9:0]};
			apb_write(REG_LEDS, d, err);
			@(negedge clk);
			exp2 = 8'hFF;
			exp5 = 8'hFF;
			if (d[10]) exp2[6] = 1'b0;             // sign, segment g
			if (d[12]) exp2[2:1] = 2'b00;          // hundreds, b and c
			if (d[11]) exp5[6] = 1'b0;
			if (d[13]) exp5[2:1] = 2'b00;
			if (hex2 != exp2 || hex5 != exp5)
				report_mismatch($sformatf("marks %b: hex2 %h hex5 %h", marks, hex2, hex5));
			if (ledr != d[9:0])
				report_mismatch($sformatf("ledr %h, expected %h", ledr, d[9:0]));
		end
		finish_test("hex display", errs_before);
	endtask

	task automatic raster_timing;
		int   m, px, py, hs_falls, last_fall, errs_before;
		logic prev_hs, prev_vs, done;
		errs_before = errors;
		wait_vs_fall();
		m         = 0;
		hs_falls  = 0;
		last_fall = -1;
		done      = 1'b0;
		prev_hs   = vga_hs;
		while (!done) begin
			px = column_at(m);
			py = line_at(m);
			if ((px >= H_ACTIVE || py >= V_ACTIVE) && {vga_r, vga_g, vga_b} != 12'h000)
				report_mismatch($sformatf("colour %h in blanking at (%0d,%0d)",
					{vga_r, vga_g, vga_b}, px, py));
			if (prev_hs && !vga_hs) begin
				if (last_fall >= 0 && m - last_fall != 2 * H_TOTAL)
					report_mismatch($sformatf("line of %0d clks", m - last_fall));
				last_fall = m;
				hs_falls++;
			end
			prev_hs = vga_hs;
			prev_vs = vga_vs;
			@(negedge clk);
			m++;
			if (prev_vs && !vga_vs)
				done = 1'b1;
		end
		if (m != FRAME_CYCLES)
			report_mismatch($sformatf("frame of %0d clks", m));
		if (hs_falls != V_TOTAL)
			report_mismatch($sformatf("%0d hsync pulses per frame", hs_falls));
		finish_test("raster timing", errs_before);
	endtask

	task automatic sprite_colour;
		apb_data_t pos;
		logic      err;
		int        m, px, py, sx, sy, dx, dy, hits, errs_before;
		errs_before = errors;
		apb_read(REG_POS, pos, err);
		sx   = pos[9:0];
		sy   = pos[25:16];
		hits = 0;
		wait_vs_fall();
		for (m = 0; m < VIS_END; m++) begin
			px = column_at(m);
			py = line_at(m);
			dx = (px > sx) ? px - sx : sx - px;
			dy = (py > sy) ? py - sy : sy - py;
			if ({vga_r, vga_g, vga_b} == {SPRITE_R, SPRITE_G, SPRITE_B})
				hits++; // painted orange anywhere
			if (px < H_ACTIVE && py < V_ACTIVE) begin
				if (dx <= SPRITE_SIZE && dy <= SPRITE_SIZE) begin
					if ({vga_r, vga_g, vga_b} != {SPRITE_R, SPRITE_G, SPRITE_B})
						report_mismatch($sformatf("(%0d,%0d) colour %h, sprite expected",
							px, py, {vga_r, vga_g, vga_b}));
				end else if ({vga_r, vga_g, vga_b} != {BG_R, BG_G, BG_B}) begin
					report_mismatch($sformatf("(%0d,%0d) colour %h, background expected",
						px, py, {vga_r, vga_g, vga_b}));
				end
			end
			@(negedge clk);
		end
		if (hits != 2 * (2 * SPRITE_SIZE + 1) ** 2) // two clks per pixel
			report_mismatch($sformatf("sprite colour on %0d clks, expected %0d",
				hits, 2 * (2 * SPRITE_SIZE + 1) ** 2));
		finish_test("sprite colour", errs_before);
	endtask

	// frame by frame model of the move and bounce rule
	task automatic follow_frames(input string key, input int n, inout apb_data_t frames,
		inout int x, inout int y, inout int vx, inout int vy);
		apb_data_t pos;
		logic      err;
		int        i, nx, ny;
		for (i = 0; i < n; i++) begin
			wait_next_frame(frames);
			nx = x + vx;
			ny = y + vy;
			if (nx < X_MIN || nx > X_MAX)
				vx = -vx; // turn, hold this frame
			else
				x = nx;
			if (ny < Y_MIN || ny > Y_MAX)
				vy = -vy;
			else
				y = ny;
			apb_read(REG_POS, pos, err);
			if (int'(pos[9:0]) != x || int'(pos[25:16]) != y)
				report_mismatch($sformatf("key %s frame %0d: at (%0d,%0d), expected (%0d,%0d)",
					key, i, pos[9:0], pos[25:16], x, y));
		end
	endtask

	task automatic motion_and_bounce;
		apb_data_t pos, frames;
		logic      err;
		int        x, y, vx, vy, errs_before;
		errs_before = errors;
		apb_write(REG_KEYCODE, {24'd0, KEY_D}, err);
		apb_read(REG_FRAMES, frames, err);
		apb_read(REG_POS, pos, err);
		x  = pos[9:0];
		y  = pos[25:16];
		vx = STEP; // right from the next frame
		vy = 0;
		follow_frames("D", (X_MAX - x) / STEP + 2, frames, x, y, vx, vy);
		apb_read(REG_POS, pos, err);
		if (int'(pos[9:0]) != X_MAX - STEP)
			report_mismatch($sformatf("x %0d after the right edge, expected %0d",
				pos[9:0], X_MAX - STEP));
		apb_write(REG_KEYCODE, {24'd0, KEY_W}, err);
		vx = 0;
		vy = -STEP; // up
		follow_frames("W", (y - Y_MIN) / STEP + 2, frames, x, y, vx, vy);
		apb_read(REG_POS, pos, err);
		if (int'(pos[25:16]) != Y_MIN + STEP)
			report_mismatch($sformatf("y %0d after the top edge, expected %0d",
				pos[25:16], Y_MIN + STEP));
		finish_test("motion", errs_before);
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		seed    = 32'hd039fc6e;
		rnd     = $urandom(seed);
		@(posedge clk);
		while (rst)
			@(posedge clk);
		reset_and_registers();
		hex_segments();
		raster_timing();
		sprite_colour(); // sprite still parked at the centre here
		motion_and_bounce();
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/apb_regs.sv
// apb register block
`timescale 1ns/1ps
`default_nettype none

module apb_regs
	import fighter_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  apb_addr_t   paddr,
	input  apb_data_t   pwdata,
	output apb_data_t   prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic        frame_tick,
	input  coord_t      sprite_x,
	input  coord_t      sprite_y,
	output keycode_t    keycode,
	output logic [15:0] hex_digits,
	output logic [13:0] led_word
);
	logic        access;    // apb access phase
	logic        mapped;
	logic        read_only;
	logic [15:0] frame_cnt;

	assign access = psel & penable;
	assign pready = 1'b1; // zero wait states

	// ==================================================
	// address decode
	// ==================================================
	always_comb begin
		mapped    = 1'b1;
		read_only = 1'b0;
		prdata    = '0;
		case (paddr)
			REG_KEYCODE: prdata = {24'd0, keycode};
			REG_HEX:     prdata = {16'd0, hex_digits};
			REG_LEDS:    prdata = {18'd0, led_word};
			REG_POS: begin
				prdata    = {6'd0, sprite_y, 6'd0, sprite_x}; // live position
				read_only = 1'b1;
			end
			REG_FRAMES: begin
				prdata    = {16'd0, frame_cnt};
				read_only = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	assign pslverr = access && (!mapped || (pwrite && read_only));

	always_ff @(posedge clk) begin
		if (rst) begin
			keycode    <= '0;
			hex_digits <= '0;
			led_word   <= '0;
			frame_cnt  <= '0;
		end else begin
			if (frame_tick)
				frame_cnt <= frame_cnt + 1'b1; // wraps at 16 bits
			if (access && pwrite) begin
				case (paddr)
					REG_KEYCODE: keycode    <= pwdata[7:0];
					REG_HEX:     hex_digits <= pwdata[15:0];
					REG_LEDS:    led_word   <= pwdata[13:0];
					default: ; // ro or unmapped, nothing changes
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fighter_pkg.sv
// fighter shared definitions
`default_nettype none

package fighter_pkg;

	// ==================================================
	// widths
	// ==================================================
	localparam int COORD_W = 10;

	typedef logic [COORD_W-1:0] coord_t;     // pixel coordinate or size
	typedef logic [3:0]         color_t;     // one vga channel
	typedef logic [3:0]         hex_digit_t;
	typedef logic [7:0]         keycode_t;   // usb usage code
	typedef logic [7:0]         apb_addr_t;
	typedef logic [31:0]        apb_data_t;

	// ==================================================
	// register map
	// ==================================================
	localparam apb_addr_t REG_KEYCODE = 8'h00; // rw, 8 bits
	localparam apb_addr_t REG_HEX     = 8'h04; // rw, four digits
	localparam apb_addr_t REG_LEDS    = 8'h08; // rw, hundreds/signs/leds
	localparam apb_addr_t REG_POS     = 8'h0C; // ro, y in 25:16, x in 9:0
	localparam apb_addr_t REG_FRAMES  = 8'h10; // ro, frame count

	// wasd usage codes
	localparam keycode_t KEY_W = 8'h1A;
	localparam keycode_t KEY_S = 8'h16;
	localparam keycode_t KEY_A = 8'h04;
	localparam keycode_t KEY_D = 8'h07;

	// orange square on blue
	localparam color_t SPRITE_R = 4'hF;
	localparam color_t SPRITE_G = 4'h7;
	localparam color_t SPRITE_B = 4'h0;
	localparam color_t BG_R     = 4'h0;
	localparam color_t BG_G     = 4'h0;
	localparam color_t BG_B     = 4'h8;

	// raster phase, also reused for the vertical axis
	typedef enum logic [1:0] {ACTIVE, FRONT, SYNC, BACK} h_phase_t;

endpackage

`default_nettype wire

// File: verilog/fighter_top.sv
// sprite display top level
`timescale 1ns/1ps
`default_nettype none

module fighter_top
	import fighter_pkg::*;
#(
	parameter int H_ACTIVE    = 640,
	parameter int H_FRONT     = 16,
	parameter int H_SYNC      = 96,
	parameter int H_BACK      = 48,
	parameter int V_ACTIVE    = 480,
	parameter int V_FRONT     = 10,
	parameter int V_SYNC      = 2,
	parameter int V_BACK      = 33,
	parameter int SPRITE_SIZE = 4,
	parameter int STEP        = 1
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  apb_addr_t   paddr,
	input  apb_data_t   pwdata,
	output apb_data_t   prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        vga_hs,
	output logic        vga_vs,
	output color_t      vga_r,
	output color_t      vga_g,
	output color_t      vga_b,
	output logic [9:0]  ledr,
	output logic [7:0]  hex0,
	output logic [7:0]  hex1,
	output logic [7:0]  hex2,
	output logic [7:0]  hex3,
	output logic [7:0]  hex4,
	output logic [7:0]  hex5
);
	pixel_if pix ();

	coord_t      sprite_x, sprite_y;
	keycode_t    keycode;
	logic [15:0] hex_digits; // four display digits
	logic [13:0] led_word;   // hundreds, signs, leds

	// ==================================================
	// raster path
	// ==================================================
	vga_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) u_timing (
		.clk (clk),
		.rst (rst),
		.pix (pix)
	);

	sprite_motion #(
		.H_ACTIVE    (H_ACTIVE),
		.V_ACTIVE    (V_ACTIVE),
		.SPRITE_SIZE (SPRITE_SIZE),
		.STEP        (STEP)
	) u_motion (
		.clk        (clk),
		.rst        (rst),
		.frame_tick (pix.frame_tick), // once per frame
		.keycode    (keycode),
		.sprite_x   (sprite_x),
		.sprite_y   (sprite_y)
	);

	pixel_colorizer #(
		.SPRITE_SIZE (SPRITE_SIZE)
	) u_color (
		.clk      (clk),
		.rst      (rst),
		.pix      (pix),
		.sprite_x (sprite_x),
		.sprite_y (sprite_y),
		.vga_r    (vga_r),
		.vga_g    (vga_g),
		.vga_b    (vga_b),
		.vga_hs   (vga_hs),
		.vga_vs   (vga_vs)
	);

	// ==================================================
	// host side
	// ==================================================
	apb_regs u_regs (
		.clk        (clk),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.frame_tick (pix.frame_tick),
		.sprite_x   (sprite_x),
		.sprite_y   (sprite_y),
		.keycode    (keycode),
		.hex_digits (hex_digits),
		.led_word   (led_word)
	);

	hex_display u_hex (
		.hex_digits (hex_digits),
		.led_word   (led_word),
		.ledr       (ledr),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5)
	);

endmodule

`default_nettype wire

// File: verilog/hex_display.sv
// seven-segment and led drive
`timescale 1ns/1ps
`default_nettype none

module hex_display
	import fighter_pkg::*;
(
	input  logic [15:0] hex_digits,
	input  logic [13:0] led_word,
	output logic [9:0]  ledr,
	output logic [7:0]  hex0,
	output logic [7:0]  hex1,
	output logic [7:0]  hex2,
	output logic [7:0]  hex3,
	output logic [7:0]  hex4,
	output logic [7:0]  hex5
);
	// segments gfedcba, active low, dp on top stays high
	function automatic logic [7:0] seg7(input hex_digit_t d);
		logic [6:0] s;
		case (d)
			4'h0: s = 7'b1000000;
			4'h1: s = 7'b1111001;
			4'h2: s = 7'b0100100;
			4'h3: s = 7'b0110000;
			4'h4: s = 7'b0011001;
			4'h5: s = 7'b0010010;
			4'h6: s = 7'b0000010;
			4'h7: s = 7'b1111000;
			4'h8: s = 7'b0000000;
			4'h9: s = 7'b0010000;
			4'hA: s = 7'b0001000;
			4'hB: s = 7'b0000011;
			4'hC: s = 7'b1000110;
			4'hD: s = 7'b0100001;
			4'hE: s = 7'b0000110;
			default: s = 7'b0001110; // F
		endcase
		return {1'b1, s};
	endfunction

	// minus on g, "1" on b and c
	function automatic logic [7:0] mark(input logic sign, input logic hundred);
		return {1'b1, ~sign, 3'b111, ~hundred, ~hundred, 1'b1};
	endfunction

	assign hex0 = seg7(hex_digits[3:0]);
	assign hex1 = seg7(hex_digits[7:4]);
	assign hex3 = seg7(hex_digits[11:8]);  // hex2 is skipped for the marks
	assign hex4 = seg7(hex_digits[15:12]);
	assign hex2 = mark(led_word[10], led_word[12]);
	assign hex5 = mark(led_word[11], led_word[13]);
	assign ledr = led_word[9:0];

endmodule

`default_nettype wire

// File: verilog/pixel_colorizer.sv
// sprite over background colour
`timescale 1ns/1ps
`default_nettype none

module pixel_colorizer
	import fighter_pkg::*;
#(
	parameter int SPRITE_SIZE = 4
) (
	input  logic   clk,
	input  logic   rst,
	pixel_if.sink  pix,
	input  coord_t sprite_x,
	input  coord_t sprite_y,
	output color_t vga_r,
	output color_t vga_g,
	output color_t vga_b,
	output logic   vga_hs,
	output logic   vga_vs
);
	coord_t dx, dy; // distance to sprite centre
	logic   in_sprite;

	assign dx = (pix.draw_x >= sprite_x) ? pix.draw_x - sprite_x : sprite_x - pix.draw_x;
	assign dy = (pix.draw_y >= sprite_y) ? pix.draw_y - sprite_y : sprite_y - pix.draw_y;
	assign in_sprite = pix.blank && (dx <= coord_t'(SPRITE_SIZE))
		&& (dy <= coord_t'(SPRITE_SIZE));

	// colour and syncs share one register stage
	always_ff @(posedge clk) begin
		if (rst) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b1; // idle high
			vga_vs <= 1'b1;
		end else begin
			vga_hs <= pix.hs;
			vga_vs <= pix.vs;
			if (in_sprite) begin
				vga_r <= SPRITE_R;
				vga_g <= SPRITE_G;
				vga_b <= SPRITE_B;
			end else if (pix.blank) begin
				vga_r <= BG_R; // visible, off sprite
				vga_g <= BG_G;
				vga_b <= BG_B;
			end else begin
				vga_r <= '0; // black in blanking
				vga_g <= '0;
				vga_b <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/pixel_if.sv
// raster signal bundle
`timescale 1ns/1ps
`default_nettype none

interface pixel_if
	import fighter_pkg::*;
();
	logic   pix_en;     // every second clk
	coord_t draw_x;
	coord_t draw_y;
	logic   blank;      // high = visible
	logic   hs;         // active low
	logic   vs;         // active low
	logic   frame_tick; // one clk at (0,0)

	modport src  (output pix_en, draw_x, draw_y, blank, hs, vs, frame_tick);
	modport sink (input pix_en, draw_x, draw_y, blank, hs, vs, frame_tick);
endinterface

`default_nettype wire

// File: verilog/sprite_motion.sv
// sprite mover with edge bounce
`timescale 1ns/1ps
`default_nettype none

module sprite_motion
	import fighter_pkg::*;
#(
	parameter int H_ACTIVE    = 640,
	parameter int V_ACTIVE    = 480,
	parameter int SPRITE_SIZE = 4,
	parameter int STEP        = 1
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     frame_tick,
	input  keycode_t keycode,
	output coord_t   sprite_x,
	output coord_t   sprite_y
);
	// signed math one bit wider than needed so underflow shows as negative
	localparam logic signed [11:0] STEP_P = 12'(STEP);
	localparam logic signed [11:0] STEP_N = -12'(STEP);
	localparam logic signed [11:0] X_MIN  = 12'(SPRITE_SIZE);
	localparam logic signed [11:0] X_MAX  = 12'(H_ACTIVE - 1 - SPRITE_SIZE);
	localparam logic signed [11:0] Y_MIN  = 12'(SPRITE_SIZE);
	localparam logic signed [11:0] Y_MAX  = 12'(V_ACTIVE - 1 - SPRITE_SIZE);

	logic signed [11:0] vel_x, vel_y; // current motion
	logic signed [11:0] vx_k, vy_k;   // motion after key
	logic signed [11:0] nx, ny;       // candidate position
	keycode_t           last_key;
	logic               x_out, y_out;

	// a key only steers when it is new, so a bounce is not undone next frame
	always_comb begin
		vx_k = vel_x;
		vy_k = vel_y;
		if (keycode != last_key) begin
			case (keycode)
				KEY_W: begin
					vx_k = '0;
					vy_k = STEP_N; // up
				end
				KEY_S: begin
					vx_k = '0;
					vy_k = STEP_P;
				end
				KEY_A: begin
					vx_k = STEP_N; // left
					vy_k = '0;
				end
				KEY_D: begin
					vx_k = STEP_P;
					vy_k = '0;
				end
				default: ; // keep going
			endcase
		end
	end

	assign nx    = $signed({2'b00, sprite_x}) + vx_k;
	assign ny    = $signed({2'b00, sprite_y}) + vy_k;
	assign x_out = (nx < X_MIN) || (nx > X_MAX);
	assign y_out = (ny < Y_MIN) || (ny > Y_MAX);

	// ==================================================
	// per-frame update
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			sprite_x <= coord_t'(H_ACTIVE / 2); // centre
			sprite_y <= coord_t'(V_ACTIVE / 2);
			vel_x    <= '0;
			vel_y    <= '0;
			last_key <= '0;
		end else if (frame_tick) begin
			last_key <= keycode;
			if (x_out) begin
				vel_x <= -vx_k; // bounce, hold position this frame
			end else begin
				vel_x    <= vx_k;
				sprite_x <= coord_t'(nx[9:0]);
			end
			if (y_out) begin
				vel_y <= -vy_k;
			end else begin
				vel_y    <= vy_k;
				sprite_y <= coord_t'(ny[9:0]);
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/vga_timing.sv
// vga raster generator
`timescale 1ns/1ps
`default_nettype none

module vga_timing
	import fighter_pkg::*;
#(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic clk,
	input  logic rst,
	pixel_if.src pix
);
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	h_phase_t h_phase, v_phase;
	logic     h_last, v_last; // last pixel of line / last line of frame

	// ==================================================
	// pixel strobe and counters
	// ==================================================
	assign h_last = (pix.draw_x == coord_t'(H_TOTAL - 1));
	assign v_last = (pix.draw_y == coord_t'(V_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			pix.pix_en     <= 1'b0;
			pix.draw_x     <= '0;
			pix.draw_y     <= '0;
			pix.frame_tick <= 1'b0;
		end else begin
			pix.pix_en     <= ~pix.pix_en;                    // clk / 2
			pix.frame_tick <= pix.pix_en & h_last & v_last; // lands on (0,0)
			if (pix.pix_en) begin
				if (h_last) begin
					pix.draw_x <= '0;
					pix.draw_y <= v_last ? '0 : pix.draw_y + 1'b1;
				end else begin
					pix.draw_x <= pix.draw_x + 1'b1;
				end
			end
		end
	end

	// phase decode from the counters
	always_comb begin
		if (pix.draw_x < coord_t'(H_ACTIVE))
			h_phase = ACTIVE;
		else if (pix.draw_x < coord_t'(H_ACTIVE + H_FRONT))
			h_phase = FRONT;
		else if (pix.draw_x < coord_t'(H_ACTIVE + H_FRONT + H_SYNC))
			h_phase = SYNC;
		else
			h_phase = BACK;

		if (pix.draw_y < coord_t'(V_ACTIVE))
			v_phase = ACTIVE;
		else if (pix.draw_y < coord_t'(V_ACTIVE + V_FRONT))
			v_phase = FRONT;
		else if (pix.draw_y < coord_t'(V_ACTIVE + V_FRONT + V_SYNC))
			v_phase = SYNC;
		else
			v_phase = BACK;
	end

	assign pix.hs    = (h_phase != SYNC); // low during pulse
	assign pix.vs    = (v_phase != SYNC);
	assign pix.blank = (h_phase == ACTIVE) && (v_phase == ACTIVE);

endmodule

`default_nettype wire
